// ==== compile.f ====
glue_pkg.sv
reset_seq.sv
rtc_tick.sv
rtc_regs.sv
bus_decoder.sv
glue_top.sv
tb_clock.sv
glue_chk.sv
glue_tb.sv

// ==== Makefile ====
TOP = glue_tb

all: sim

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

sim: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@grep -q "Result: PASSED" sim.log
	@! grep -q "Result: FAILED" sim.log

lint:
	verilator --lint-only --timing --assert -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build sim lint clean

// ==== glue_tb.sv ====
// system glue testbench
`timescale 1ns/1ps

module glue_tb;
	import glue_pkg::*;

	localparam int TEST_CYCLES = 4000;	// rough sum of all test lengths

	logic clk, rst, sof, mrst, cpurst, sys_reset, cpu_reset_n;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;
	ram_req_t ram_req;
	rtc_host_t rtc_host;
	cpu_data_t ram_rdata = '0;
	int n_mis, n_err, cyc;
	logic [15:0] chip_mem [int];	// ram model, chip bank
	logic [15:0] exp_chip [int];	// expected chip contents
	logic [15:0] kick_mem [0:(1<<KICK_AW)-1];

	tb_clock clk_gen_i (.clk(clk), .rst(rst));

	glue_top #(.RTC_DIV(50)) dut_i (.clk(clk), .rst(rst), .sof(sof), .mrst(mrst),
		.cpurst(cpurst), .cpu_req(cpu_req), .rtc_host(rtc_host), .ram_rdata(ram_rdata),
		.cpu_rsp(cpu_rsp), .ram_req(ram_req), .sys_reset(sys_reset),
		.cpu_reset_n(cpu_reset_n));

	// kick pattern, every address bit matters
	function automatic logic [15:0] kick_word(logic [17:0] idx);
		return idx[15:0] ^ {idx[17:16], idx[17:16], 12'hC35};
	endfunction

	// ------------------------------------------------------------
	// ram model, one cycle read latency
	// ------------------------------------------------------------
	always @(posedge clk) begin
		logic [15:0] w;
		int a;
		a = int'(ram_req.addr);
		if (ram_req.bank == BANK_KICK) w = kick_mem[a[KICK_AW-1:0]];
		else w = chip_mem.exists(a) ? chip_mem[a] : 16'h0000;
		if (ram_req.rd) ram_rdata <= w;
		if (ram_req.hwr) w[15:8] = ram_req.wdata[15:8];
		if (ram_req.lwr) w[7:0] = ram_req.wdata[7:0];
		if (ram_req.hwr || ram_req.lwr) begin
			if (ram_req.bank == BANK_KICK) kick_mem[a[KICK_AW-1:0]] = w;
			else chip_mem[a] = w;
		end
		cyc <= cyc + 1;
	end

	// expected read value from the address map
	function automatic logic [15:0] ref_read(cpu_addr_t a, logic ovl_on);
		logic [7:0] page;
		page = a[22:15];
		if (page >= 8'hF8 || (ovl_on && page < 8'h08)) return kick_word(a[17:0]);
		if (page < 8'h20) return exp_chip.exists(int'(a[19:0])) ? exp_chip[int'(a[19:0])] : '0;
		return 16'h0000;	// cia and holes
	endfunction

	function automatic logic [7:0] ref_bcd_sec(int k);
		int v;
		v = (k > 59) ? 59 : k;	// saturates
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	task automatic check_eq(string name, logic [63:0] got, logic [63:0] exp);
		if (got !== exp) begin
			n_mis++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// one request, wait for its ack
	task automatic bus_access(cpu_addr_t a, logic rd, logic hw, logic lw,
			cpu_data_t d, output cpu_data_t q);
		int lat;
		cpu_req = '{stb: 1'b1, rd: rd, hwr: hw, lwr: lw, addr: a, wdata: d};
		lat = 1;
		@(posedge clk);
		#2 cpu_req.stb = 1'b0;
		while (!cpu_rsp.ack && lat < 5) begin
			@(posedge clk);
			#2 lat++;
		end
		if (!cpu_rsp.ack) begin
			n_err++;
			$display("no acknowledge for address %h", a);
		end
		check_eq("ack latency", lat, 1);
		q = cpu_rsp.rdata;
	endtask

	task automatic read_check(cpu_addr_t a, logic [15:0] exp);
		cpu_data_t q;
		bus_access(a, 1'b1, 1'b0, 1'b0, '0, q);
		check_eq($sformatf("rdata[%h]", a), q, exp);
	endtask

	task automatic pulse_sof(logic exp_sys);
		sof = 1'b1;
		@(posedge clk);
		#2 sof = 1'b0;
		check_eq("sys_reset", sys_reset, exp_sys);
		repeat (3) @(posedge clk);
		#2;
	endtask

	task automatic wait_cpu_release();
		@(posedge clk);
		#2 check_eq("cpu_reset_n", cpu_reset_n, 0);
		@(posedge clk);
		#2 check_eq("cpu_reset_n", cpu_reset_n, 1);
	endtask

	initial begin
		cpu_data_t q;
		cpu_addr_t a;
		int c0;
		int secs [8];	// elapsed seconds to sample
		logic [7:0] bcd;
		logic [1:0] be;
		cpu_addr_t addrs [$];
		n_mis = 0;
		n_err = 0;
		void'($urandom(53));
		{sof, mrst, cpurst} = 3'b000;
		cpu_req = '0;
		rtc_host = '0;
		for (int i = 0; i < (1 << KICK_AW); i++) kick_mem[i] = kick_word(18'(i));
		@(negedge rst);
		@(posedge clk);
		#2;
		// reset sequence, then mrst in run mode
		for (int i = 1; i <= 4; i++) pulse_sof(i < 4);
		check_eq("cpu_reset_n", cpu_reset_n, 1);	// already two cycles past release
		mrst = 1'b1;
		@(posedge clk);
		#2 mrst = 1'b0;
		check_eq("sys_reset", sys_reset, 1);
		for (int i = 1; i <= 4; i++) pulse_sof(1'b1);
		sof = 1'b1;
		@(posedge clk);
		#2 sof = 1'b0;
		check_eq("sys_reset", sys_reset, 0);
		wait_cpu_release();
		// ------------------------------------------------------------
		// overlay
		// ------------------------------------------------------------
		bus_access('0, 1'b0, 1'b1, 1'b1, 16'h1234, q);	// lands in chip
		exp_chip[0] = 16'h1234;
		read_check('0, ref_read('0, 1'b1));
		bus_access({8'hBF, 15'h0800}, 1'b0, 1'b0, 1'b1, 16'h00FF, q);	// cia b
		read_check('0, ref_read('0, 1'b1));
		bus_access({8'hBF, 15'h0000}, 1'b0, 1'b0, 1'b1, 16'h00FF, q);	// cia a
		read_check('0, ref_read('0, 1'b0));
		// chip ram round trip
		for (int i = 0; i < 24; i++) begin
			a = 23'($urandom & 32'h000F_FFFF);
			be = 2'($urandom % 3 + 1);
			q = 16'($urandom);
			bus_access(a, 1'b0, be[1], be[0], q, q);
			q = ref_read(a, 1'b0);
			if (be[1]) q[15:8] = cpu_req.wdata[15:8];
			if (be[0]) q[7:0] = cpu_req.wdata[7:0];
			exp_chip[int'(a[19:0])] = q;
			addrs.push_back(a);
		end
		foreach (addrs[i]) read_check(addrs[i], ref_read(addrs[i], 1'b0));
		// rom protection and cia reads
		for (int i = 0; i < 6; i++) begin
			a = {8'hF8 + 8'($urandom % 8), 15'($urandom)};
			bus_access(a, 1'b0, 1'b1, 1'b1, 16'($urandom), q);
			read_check(a, ref_read(a, 1'b0));
			read_check({8'hBF, 15'($urandom)}, 16'h0000);
		end
		// ------------------------------------------------------------
		// battery clock
		// ------------------------------------------------------------
		rtc_host = '{flg: 1'b1, tval: 64'h0123_4567_89AB_CD77};
		c0 = cyc + 2;	// cycle the load takes effect
		secs = '{0, 1, 5, 9, 10, 23, 59, 62};
		foreach (secs[j]) begin
			while (cyc < c0 + 50 * secs[j] + 23) @(posedge clk);
			bcd = ref_bcd_sec(secs[j]);
			#2 read_check({8'hDC, 15'h0000}, {12'h000, bcd[3:0]});
			read_check({8'hDC, 15'h0002}, {12'h000, bcd[7:4]});
		end
		for (int n = 2; n < 16; n++)
			read_check({8'hDC, 15'(n << 1)}, {12'h000, rtc_host.tval[n*4 +: 4]});
		$display("errors: %0d mismatches, %0d other", n_mis, n_err);
		if (n_mis == 0 && n_err == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TEST_CYCLES * 40 * 3 / 2);
		$display("simulation timed out before the tests completed");
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== glue_chk.sv ====
// bus and reset assertions
`timescale 1ns/1ps

module glue_chk (
	input logic clk,
	input logic rst,
	input logic stb,
	input logic ack,
	input logic kick_wr,	// write enable aimed at the kick bank
	input logic sys_reset,
	input logic cpu_reset_n
);

	a_ack_follows: assert property (@(posedge clk) disable iff (rst) stb |=> ack)
		else $error("ack missing one cycle after request");
	a_ack_only: assert property (@(posedge clk) disable iff (rst) ack |-> $past(stb))
		else $error("ack without request");
	a_rom_wr: assert property (@(posedge clk) disable iff (rst) !kick_wr)
		else $error("write enable high for kick bank");
	a_cpu_rel: assert property (@(posedge clk) disable iff (rst)
		$fell(sys_reset) |-> ##2 $rose(cpu_reset_n))
		else $error("cpu reset release not two cycles after system reset");

endmodule

bind bus_decoder glue_chk bus_chk_i (
	.clk(clk), .rst(rst), .stb(cpu_req.stb), .ack(cpu_rsp.ack),
	.kick_wr((ram_req.bank == glue_pkg::BANK_KICK) && (ram_req.hwr || ram_req.lwr)),
	.sys_reset(1'b1), .cpu_reset_n(1'b0)
);

bind reset_seq glue_chk seq_chk_i (
	.clk(clk), .rst(rst), .stb(1'b0), .ack(1'b0), .kick_wr(1'b0),
	.sys_reset(sys_reset), .cpu_reset_n(cpu_reset_n)
);

// ==== tb_clock.sv ====
// testbench clock and reset
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (10) @(posedge clk);
		#2 rst = 1'b0;	// released like any other stimulus
	end

endmodule

// ==== glue_top.sv ====
// system glue top level
`timescale 1ns/1ps

module glue_top #(
	parameter int RTC_DIV = glue_pkg::RTC_DIV_DEFAULT
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                sof,
	input  logic                mrst,
	input  logic                cpurst,
	input  glue_pkg::cpu_req_t  cpu_req,
	input  glue_pkg::rtc_host_t rtc_host,
	input  glue_pkg::cpu_data_t ram_rdata,
	output glue_pkg::cpu_rsp_t  cpu_rsp,
	output glue_pkg::ram_req_t  ram_req,
	output logic                sys_reset,
	output logic                cpu_reset_n
);
	import glue_pkg::*;

	logic       rtc_load;	// host set the clock
	logic       sec_tick;
	rtc_nib_t   nib_sel;
	logic [3:0] nib_data;

	// ------------------------------------------------------------
	// reset
	// ------------------------------------------------------------
	reset_seq reset_seq_i (
		.clk         (clk),
		.rst         (rst),
		.sof         (sof),
		.mrst        (mrst),
		.cpurst      (cpurst),
		.sys_reset   (sys_reset),
		.cpu_reset_n (cpu_reset_n)
	);

	// ------------------------------------------------------------
	// battery clock
	// ------------------------------------------------------------
	rtc_tick #(
		.RTC_DIV (RTC_DIV)
	) rtc_tick_i (
		.clk      (clk),
		.rst      (rst),
		.rtc_load (rtc_load),
		.sec_tick (sec_tick)
	);

	rtc_regs rtc_regs_i (
		.clk      (clk),
		.rst      (rst),
		.rtc_host (rtc_host),
		.sec_tick (sec_tick),
		.nib_sel  (nib_sel),
		.rtc_load (rtc_load),
		.nib_data (nib_data)
	);

	// cpu side decode
	bus_decoder bus_decoder_i (
		.clk         (clk),
		.rst         (rst),
		.cpu_reset_n (cpu_reset_n),
		.cpu_req     (cpu_req),
		.ram_rdata   (ram_rdata),
		.nib_data    (nib_data),
		.cpu_rsp     (cpu_rsp),
		.ram_req     (ram_req),
		.nib_sel     (nib_sel)
	);

endmodule

// ==== bus_decoder.sv ====
// cpu bus decoder and read merge
`timescale 1ns/1ps

module bus_decoder (
	input  logic                clk,
	input  logic                rst,
	input  logic                cpu_reset_n,
	input  glue_pkg::cpu_req_t  cpu_req,
	input  glue_pkg::cpu_data_t ram_rdata,	// valid in the ack cycle
	input  logic [3:0]          nib_data,
	output glue_pkg::cpu_rsp_t  cpu_rsp,
	output glue_pkg::ram_req_t  ram_req,
	output glue_pkg::rtc_nib_t  nib_sel
);
	import glue_pkg::*;

	logic [7:0] page;	// cpu address bits 23..16
	logic       sel_chip;
	logic       sel_kick;
	logic       sel_cia;
	logic       sel_cia_a;
	logic       sel_rtc;
	logic       ovl_win;	// inside the boot overlay window
	logic       use_kick;	// access lands in the kick bank
	logic       wr;
	logic       ovl;	// kickstart overlay

	logic       ack_q;
	logic       src_ram_q;	// ack carries ram data
	logic       src_rtc_q;	// ack carries a clock nibble

	// ------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------
	assign page      = cpu_req.addr[22:15];
	assign sel_chip  = (page < CHIP_TOP);
	assign sel_kick  = (page >= KICK_BASE);
	assign sel_cia   = (page == CIA_PAGE);
	assign sel_cia_a = sel_cia & ~cpu_req.addr[11];	// A12 low
	assign sel_rtc   = (page == RTC_PAGE);
	assign ovl_win   = (page < OVL_TOP);
	assign wr        = cpu_req.hwr | cpu_req.lwr;

	// reads in the window go to rom while the overlay is on, writes stay in chip
	assign use_kick = sel_kick | (ovl & ovl_win & cpu_req.rd);

	// ------------------------------------------------------------
	// overlay latch
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst || !cpu_reset_n)
			ovl <= 1'b1;	// boot from rom
		else if (cpu_req.stb && wr && sel_cia_a)
			ovl <= 1'b0;	// any cia a write, data ignored
	end

	// ------------------------------------------------------------
	// ram port, straight from the request
	// ------------------------------------------------------------
	always_comb begin
		ram_req.rd    = cpu_req.stb & cpu_req.rd & (sel_chip | sel_kick);
		// rom area is write protected
		ram_req.hwr   = cpu_req.stb & cpu_req.hwr & sel_chip & ~use_kick;
		ram_req.lwr   = cpu_req.stb & cpu_req.lwr & sel_chip & ~use_kick;
		ram_req.bank  = use_kick ? BANK_KICK : BANK_CHIP;
		ram_req.wdata = cpu_req.wdata;
		if (use_kick)
			ram_req.addr = RAM_AW'(cpu_req.addr[KICK_AW-1:0]);	// rom mirrors in 512K
		else
			ram_req.addr = cpu_req.addr[RAM_AW-1:0];
	end

	// ------------------------------------------------------------
	// acknowledge and source select
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q     <= 1'b0;
			src_ram_q <= 1'b0;
			src_rtc_q <= 1'b0;
		end else begin
			ack_q     <= cpu_req.stb;	// no wait states
			src_ram_q <= cpu_req.stb & cpu_req.rd & (sel_chip | sel_kick);
			src_rtc_q <= cpu_req.stb & cpu_req.rd & sel_rtc;
		end
	end

	// nibble index held for the ack cycle, A5..A2
	always_ff @(posedge clk) begin
		if (cpu_req.stb)
			nib_sel <= cpu_req.addr[4:1];
	end

	// read merge, cia space and holes read as zero
	always_comb begin
		cpu_rsp.ack = ack_q;
		if (src_ram_q)
			cpu_rsp.rdata = ram_rdata;
		else if (src_rtc_q)
			cpu_rsp.rdata = {12'h000, nib_data};
		else
			cpu_rsp.rdata = '0;
	end

endmodule

// ==== rtc_regs.sv ====
// battery clock register
`timescale 1ns/1ps

module rtc_regs (
	input  logic                 clk,
	input  logic                 rst,
	input  glue_pkg::rtc_host_t  rtc_host,
	input  logic                 sec_tick,
	input  glue_pkg::rtc_nib_t   nib_sel,
	output logic                 rtc_load,	// to the divider
	output logic [3:0]           nib_data
);
	import glue_pkg::*;

	logic      flg_s;	// host flag, sampled
	logic      flg_d;	// previous sample
	rtc_time_t tval_s;	// host time, sampled with the flag
	rtc_time_t time_q;	// running clock

	// ------------------------------------------------------------
	// host toggle detect
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			flg_s <= 1'b0;
			flg_d <= 1'b0;
		end else begin
			flg_s <= rtc_host.flg;
			flg_d <= flg_s;
		end
	end

	always_ff @(posedge clk) begin
		tval_s <= rtc_host.tval;	// stays in step with flg_s
	end

	assign rtc_load = flg_s ^ flg_d;

	// ------------------------------------------------------------
	// load and bcd seconds
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			time_q <= '0;
		end else if (rtc_load) begin
			time_q <= {tval_s[63:8], 8'h00};	// seconds restart at 00
		end else if (sec_tick) begin
			if (time_q[3:0] < 4'd9) begin
				time_q[3:0] <= time_q[3:0] + 1'b1;	// units
			end else if (time_q[7:4] < 4'd5) begin
				time_q[7:4] <= time_q[7:4] + 1'b1;	// tens, units wrap
				time_q[3:0] <= 4'd0;
			end
			// 59 holds, minutes are not carried
		end
	end

	// nibble read-out for the cpu
	assign nib_data = time_q[{nib_sel, 2'b00} +: 4];

endmodule

// ==== rtc_tick.sv ====
// seconds tick divider
`timescale 1ns/1ps

module rtc_tick #(
	parameter int RTC_DIV = glue_pkg::RTC_DIV_DEFAULT	// clk cycles per second
) (
	input  logic clk,
	input  logic rst,
	input  logic rtc_load,	// restart the second
	output logic sec_tick
);

	localparam int CW = (RTC_DIV > 1) ? $clog2(RTC_DIV) : 1;

	logic [CW-1:0] cnt;	// cycles into the current second

	// ------------------------------------------------------------
	// divide down to one pulse per second
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			cnt      <= '0;
			sec_tick <= 1'b0;
		end else if (rtc_load) begin
			cnt      <= '0;	// host just set the time
			sec_tick <= 1'b0;
		end else if (cnt == CW'(RTC_DIV - 1)) begin
			cnt      <= '0;
			sec_tick <= 1'b1;	// single cycle pulse
		end else begin
			cnt      <= cnt + 1'b1;
			sec_tick <= 1'b0;
		end
	end

endmodule

// ==== reset_seq.sv ====
// system reset sequencer
`timescale 1ns/1ps

module reset_seq (
	input  logic clk,
	input  logic rst,
	input  logic sof,	// start of video frame
	input  logic mrst,	// master reset request
	input  logic cpurst,	// reset instruction from the cpu
	output logic sys_reset,
	output logic cpu_reset_n
);
	import glue_pkg::*;

	seq_state_t          state;
	logic [FRAME_CW-1:0] frame_cnt;	// sof pulses seen in hold
	logic                rst_sync;	// first sync stage

	// ------------------------------------------------------------
	// frame stretch fsm
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= SEQ_HOLD;
			frame_cnt <= '0;
		end else begin
			case (state)
				SEQ_HOLD: begin
					if (mrst) begin
						frame_cnt <= '0;	// restart the count
					end else if (sof) begin
						if (frame_cnt == FRAME_CW'(RESET_FRAMES - 1)) begin
							state     <= SEQ_RUN;
							frame_cnt <= '0;
						end else begin
							frame_cnt <= frame_cnt + 1'b1;
						end
					end
				end
				SEQ_RUN: begin
					if (mrst)
						state <= SEQ_WAIT_FRAME;	// reset goes up right away
				end
				SEQ_WAIT_FRAME: begin
					// align to a frame boundary before counting
					if (sof && !mrst)
						state <= SEQ_HOLD;
				end
				default: begin
					state     <= SEQ_HOLD;
					frame_cnt <= '0;
				end
			endcase
		end
	end

	assign sys_reset = (state != SEQ_RUN);	// held in hold and wait

	// ------------------------------------------------------------
	// cpu reset, two register stages
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			rst_sync    <= 1'b0;
			cpu_reset_n <= 1'b0;
		end else begin
			rst_sync    <= ~(sys_reset | cpurst);
			cpu_reset_n <= rst_sync;
		end
	end

endmodule

// ==== glue_pkg.sv ====
// system glue shared definitions
package glue_pkg;

	// ------------------------------------------------------------
	// widths that carry a meaning
	// ------------------------------------------------------------
	typedef logic [22:0] cpu_addr_t;	// word address, cpu A23..A1
	typedef logic [15:0] cpu_data_t;	// one bus word
	typedef logic [63:0] rtc_time_t;	// 16 bcd nibbles, seconds in the low byte
	typedef logic [3:0]  rtc_nib_t;	// nibble index into rtc_time_t

	localparam int RAM_AW  = 20;	// word address inside one ram bank, 2MB of chip
	localparam int KICK_AW = 18;	// 512KB kickstart window

	// reset stretch in video frames
	localparam int RESET_FRAMES = 4;
	localparam int FRAME_CW     = (RESET_FRAMES > 1) ? $clog2(RESET_FRAMES) : 1;

	// ------------------------------------------------------------
	// address map, compared against cpu address bits 23..16
	// ------------------------------------------------------------
	localparam logic [7:0] CHIP_TOP  = 8'h20;	// chip ram below this page
	localparam logic [7:0] OVL_TOP   = 8'h08;	// overlay window below this page
	localparam logic [7:0] CIA_PAGE  = 8'hBF;	// both cias
	localparam logic [7:0] RTC_PAGE  = 8'hDC;	// battery clock
	localparam logic [7:0] KICK_BASE = 8'hF8;	// kickstart rom and up

	// pal system clock, 28.37516 MHz
	localparam int RTC_DIV_DEFAULT = 28_375_160;

	typedef enum logic [1:0] {
		SEQ_HOLD,	// counting frames with reset held
		SEQ_RUN,	// system running
		SEQ_WAIT_FRAME	// reset requested, waiting for frame start
	} seq_state_t;

	typedef enum logic {
		BANK_CHIP,
		BANK_KICK
	} ram_bank_t;

	// cpu side request, strobe is high for one cycle
	typedef struct packed {
		logic      stb;
		logic      rd;
		logic      hwr;	// upper byte write
		logic      lwr;	// lower byte write
		cpu_addr_t addr;
		cpu_data_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic      ack;	// one cycle after stb
		cpu_data_t rdata;
	} cpu_rsp_t;

	typedef struct packed {
		logic              rd;
		logic              hwr;
		logic              lwr;
		ram_bank_t         bank;
		logic [RAM_AW-1:0] addr;	// word inside the bank
		cpu_data_t         wdata;
	} ram_req_t;

	// host side clock load, a toggle of flg loads tval
	typedef struct packed {
		logic      flg;
		rtc_time_t tval;
	} rtc_host_t;

endpackage
